//--- include/mul_cfg.svh
// configuration macros for the iterative multiply unit
// include this wherever widths, depths or credit counts are needed

`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// operand width of the processor datapath
`define MUL_DATA_W 64

// bits of operand a consumed by the core on each step
`define MUL_DIGIT_W 16

// number of core steps for one multiply
`define MUL_STEPS (`MUL_DATA_W / `MUL_DIGIT_W)

// request queue depth, equal to the issuer's starting credit count
`define MUL_REQ_DEPTH 4

// result queue depth inside the unit
`define MUL_RSP_DEPTH 2

// writeback buffer size, which sets the unit's starting response credits
`define MUL_WB_CREDITS 3

// width of every credit counter
`define MUL_CRD_W 3

`endif

//--- logic/mulReqPkg.sv
// request side types of the multiply unit
// used by the issue interface, operand selection and the core input

`default_nettype none

`include "mul_cfg.svh"

package mulReqPkg;

	// tag that follows a request through to its result
	typedef logic [3:0] mulTag_t;

	// one operand word
	typedef logic [`MUL_DATA_W-1:0] mulWord_t;

	// operation flags sent with each request
	typedef struct packed {
		logic isSigned;
		logic useImm;
	} mulOp_t;

	// request as it leaves the issue stage
	typedef struct packed {
		mulTag_t  tag;
		mulOp_t   op;
		mulWord_t a;
		mulWord_t b;
		mulWord_t imm;
	} mulReq_t;

	// magnitudes and result sign handed to the core on ld
	typedef struct packed {
		mulWord_t magA;
		mulWord_t magB;
		logic     neg;
		mulTag_t  tag;
	} mulOperands_t;

endpackage

`default_nettype wire

//--- logic/mulRspPkg.sv
// response side types of the multiply unit
// used by the core output, the result queue and the writeback interface

`default_nettype none

`include "mul_cfg.svh"

package mulRspPkg;

	// full width product, twice the operand width
	typedef logic [2*`MUL_DATA_W-1:0] mulProduct_t;

	// result returned to writeback
	// the tag type comes from the request side so both ends agree on it
	typedef struct packed {
		mulReqPkg::mulTag_t tag;
		mulProduct_t        product;
	} mulRsp_t;

endpackage

`default_nettype wire

//--- logic/creditFifo.sv
// synchronous FIFO with a type parameterized payload
// pulses credit for one cycle after every pop so the sender can count slots

`timescale 1ns/100ps
`default_nettype none

module creditFifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  T     pushData,
	input  logic pop,
	output T     popData,
	output logic empty,
	output logic full,
	output logic credit
);

	// a one entry queue still needs a one bit pointer
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// ==================================================
	// storage and pointers
	// ==================================================

	T mem [DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;

	// the head entry is read straight out of the array
	assign popData = mem[rdPtr];
	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(DEPTH));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= pushData;
		end
	end

	// ==================================================
	// pointer, occupancy and credit bookkeeping
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			// pointers wrap explicitly so DEPTH need not be a power of two
			if (push) begin
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end

			// a push and a pop together leave the occupancy unchanged
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			// one slot freed per pop, reported on the following cycle
			credit <= pop;
		end
	end

endmodule

`default_nettype wire

//--- logic/mulOperandSel.sv
// operand selection ahead of the multiply core
// picks b or the immediate and turns signed operands into sign and magnitude

`timescale 1ns/100ps
`default_nettype none

`include "mul_cfg.svh"

module mulOperandSel
	import mulReqPkg::*;
(
	input  mulReq_t      req,
	output mulOperands_t operands
);

	// second operand before any sign handling
	mulWord_t opB;

	// sign bits of the two operands
	logic signA;
	logic signB;

	assign opB   = req.op.useImm ? req.imm : req.b;
	assign signA = req.a[`MUL_DATA_W-1];
	assign signB = opB[`MUL_DATA_W-1];

	always_comb begin
		operands.tag = req.tag;
		if (req.op.isSigned) begin
			// negating the most negative value gives the same bit pattern
			// which is exactly its magnitude when read as unsigned
			operands.magA = signA ? -req.a : req.a;
			operands.magB = signB ? -opB : opB;
			// product is negative when exactly one operand is
			operands.neg  = signA ^ signB;
		end else begin
			// unsigned operands go through untouched
			operands.magA = req.a;
			operands.magB = opB;
			operands.neg  = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/mulIterCore.sv
// iterative multiplier that consumes one digit of the first magnitude per step
// ld captures the operands, done pulses for one cycle with the signed result

`timescale 1ns/100ps
`default_nettype none

`include "mul_cfg.svh"

module mulIterCore
	import mulReqPkg::*;
	import mulRspPkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         ld,
	input  mulOperands_t operands,
	output logic         done,
	output mulRsp_t      result
);

	localparam int DATA_W  = `MUL_DATA_W;
	localparam int DIGIT_W = `MUL_DIGIT_W;
	localparam int CNT_W   = $clog2(`MUL_STEPS + 1);

	typedef enum logic [1:0] {
		IDLE,
		MULT,
		DONE
	} coreState_t;

	coreState_t state;

	// counts the remaining digit steps, zero means the finishing cycle
	logic [CNT_W-1:0] stepCnt;

	// working copies of the operands
	mulWord_t    magA;
	mulWord_t    magB;
	logic        neg;
	mulTag_t     tag;
	mulProduct_t prod;

	// one digit times the full second magnitude, plus the running upper half
	logic [DATA_W+DIGIT_W-1:0] partial;

	assign partial = magB * magA[DIGIT_W-1:0] + prod[2*DATA_W-1:DATA_W];

	assign done = (state == DONE);

	// ==================================================
	// control
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			stepCnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (ld) begin
						stepCnt <= CNT_W'(`MUL_STEPS);
						state   <= MULT;
					end
				end
				MULT: begin
					if (stepCnt != '0) begin
						stepCnt <= stepCnt - 1'b1;
					end else begin
						state <= DONE;
					end
				end
				// done lasts a single cycle, the next ld can follow at once
				default: state <= IDLE;
			endcase
		end
	end

	// ==================================================
	// datapath
	// ==================================================

	always_ff @(posedge clk) begin
		if (state == IDLE && ld) begin
			magA <= operands.magA;
			magB <= operands.magB;
			neg  <= operands.neg;
			tag  <= operands.tag;
			prod <= '0;
		end else if (state == MULT) begin
			if (stepCnt != '0) begin
				// retire the low digit of a and shift the product down by one digit
				magA <= {{DIGIT_W{1'b0}}, magA[DATA_W-1:DIGIT_W]};
				prod <= {partial, prod[DATA_W-1:DIGIT_W]};
			end else begin
				// finishing cycle restores the sign and registers the result
				result.product <= neg ? -prod : prod;
				result.tag     <= tag;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/mulUnit.sv
// top level of the multiply unit
// requests are queued, multiplied one at a time and returned under credit control

`timescale 1ns/100ps
`default_nettype none

`include "mul_cfg.svh"

module mulUnit
	import mulReqPkg::*;
	import mulRspPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    reqValid,
	input  mulReq_t reqData,
	output logic    reqCredit,
	output logic    rspValid,
	output mulRsp_t rspData,
	input  logic    rspCredit
);

	localparam int RESV_W = $clog2(`MUL_RSP_DEPTH + 1);

	// request queue head and state
	mulReq_t      reqHead;
	logic         reqEmpty;

	// core interface
	mulOperands_t operands;
	logic         ld;
	logic         coreDone;
	mulRsp_t      coreResult;
	logic         busy;

	// result queue state
	logic         rspEmpty;
	logic         rspFree;

	// result slots claimed by the core or still held in the result queue
	logic [RESV_W-1:0] resv;

	// credits left in the writeback buffer
	logic [`MUL_CRD_W-1:0] rspCrd;

	// ==================================================
	// request path
	// ==================================================

	// the issuer never sends without a credit, so the queue cannot overflow
	creditFifo #(
		.T     (mulReq_t),
		.DEPTH (`MUL_REQ_DEPTH)
	) reqFifo_i (
		.clk      (clk),
		.rst      (rst),
		.push     (reqValid),
		.pushData (reqData),
		.pop      (ld),
		.popData  (reqHead),
		.empty    (reqEmpty),
		.full     (),
		.credit   (reqCredit)
	);

	mulOperandSel opSel_i (
		.req      (reqHead),
		.operands (operands)
	);

	// start only when a result slot can be reserved for this operation
	assign ld = !reqEmpty && !busy && (resv < RESV_W'(`MUL_RSP_DEPTH));

	mulIterCore core_i (
		.clk      (clk),
		.rst      (rst),
		.ld       (ld),
		.operands (operands),
		.done     (coreDone),
		.result   (coreResult)
	);

	// ==================================================
	// response path
	// ==================================================

	creditFifo #(
		.T     (mulRsp_t),
		.DEPTH (`MUL_RSP_DEPTH)
	) rspFifo_i (
		.clk      (clk),
		.rst      (rst),
		.push     (coreDone),
		.pushData (coreResult),
		.pop      (rspValid),
		.popData  (rspData),
		.empty    (rspEmpty),
		.full     (),
		.credit   (rspFree)
	);

	// a result leaves only while writeback has room for it
	assign rspValid = !rspEmpty && (rspCrd != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy   <= 1'b0;
			resv   <= '0;
			rspCrd <= `MUL_CRD_W'(`MUL_WB_CREDITS);
		end else begin
			// the core is busy from ld until its done pulse
			if (ld) begin
				busy <= 1'b1;
			end else if (coreDone) begin
				busy <= 1'b0;
			end

			// slot is claimed on ld and released by the queue's pop credit
			case ({ld, rspFree})
				2'b10:   resv <= resv + 1'b1;
				2'b01:   resv <= resv - 1'b1;
				default: resv <= resv;
			endcase

			// sending and a returned credit in one cycle cancel out
			case ({rspValid, rspCredit})
				2'b10:   rspCrd <= rspCrd - 1'b1;
				2'b01:   rspCrd <= rspCrd + 1'b1;
				default: rspCrd <= rspCrd;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tb/mulScoreboard.sv
// scoreboard for the multiply unit testbench
// the testbench hands over expected results in issue order, each response is checked here

`timescale 1ns/100ps
`default_nettype none

`include "mul_cfg.svh"

module mulScoreboard
	import mulReqPkg::*;
	import mulRspPkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    reqValid,
	input logic    reqCredit,
	input logic    rspValid,
	input mulRsp_t rspData,
	input int      wbCrd
);

	int dataErrs = 0;
	int protoErrs = 0;
	int reqCount = 0;
	int creditCount = 0;

	// expected results, oldest at the front
	mulTag_t     expTags[$];
	mulProduct_t expProds[$];

	task automatic addExpected(input mulTag_t tag, input mulProduct_t product);
		expTags.push_back(tag);
		expProds.push_back(product);
	endtask

	task automatic checkResponse();
		mulTag_t     expTag;
		mulProduct_t expProd;
		// writeback must have had room for this result
		if (wbCrd == 0) begin
			$display("response with tag %h was sent while writeback had no free credit",
				rspData.tag);
			protoErrs++;
		end
		if (expTags.size() == 0) begin
			$display("response with tag %h arrived with no request outstanding", rspData.tag);
			protoErrs++;
		end else begin
			expTag  = expTags.pop_front();
			expProd = expProds.pop_front();
			if (rspData.tag !== expTag) begin
				$display("FAIL rspData.tag: got %h, expected %h", rspData.tag, expTag);
				dataErrs++;
			end
			if (rspData.product !== expProd) begin
				$display("FAIL rspData.product: got %h, expected %h", rspData.product, expProd);
				dataErrs++;
			end
		end
	endtask

	// called once the run has drained
	task automatic checkDrain(input int issuerCrd);
		if (creditCount != reqCount) begin
			$display("FAIL reqCredit count: got %h, expected %h", creditCount, reqCount);
			dataErrs++;
		end
		if (issuerCrd != `MUL_REQ_DEPTH) begin
			$display("FAIL issuer credits: got %h, expected %h", issuerCrd, `MUL_REQ_DEPTH);
			dataErrs++;
		end
		if (expTags.size() != 0) begin
			$display("%0d results never came back from the unit", expTags.size());
			protoErrs++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			if (reqValid) begin
				reqCount++;
			end
			if (reqCredit) begin
				creditCount++;
			end
			if (rspValid) begin
				checkResponse();
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/mulUnit_chk.sv
// assertions bound into the multiply unit
// cover the response credit counter, request credit pulses and the reset state

`timescale 1ns/100ps
`default_nettype none

`include "mul_cfg.svh"

module mulUnit_chk (
	input logic                  clk,
	input logic                  rst,
	input logic                  reqCredit,
	input logic                  rspValid,
	input logic                  rspCredit,
	input logic [`MUL_CRD_W-1:0] rspCrd
);

	// assertion failures seen so far
	int failCount = 0;

	// results that writeback still holds, counted from the port handshake alone
	int held;

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 0;
		end else begin
			held <= held + (rspValid ? 1 : 0) - (rspCredit ? 1 : 0);
		end
	end

	// a result may only leave while writeback has room for it
	rspNeedsCredit: assert property (@(posedge clk) disable iff (rst)
		rspValid |-> held < `MUL_WB_CREDITS)
		else begin
			failCount++;
			$error("response sent while writeback had no free slot");
		end

	// the counter can never hold more than the writeback buffer size
	crdBounded: assert property (@(posedge clk) disable iff (rst)
		rspCrd <= `MUL_CRD_W'(`MUL_WB_CREDITS))
		else begin
			failCount++;
			$error("response credit counter above the writeback buffer size");
		end

	// writeback only returns credits for results it actually holds
	crdReturnLegal: assert property (@(posedge clk) disable iff (rst)
		rspCredit |-> rspCrd < `MUL_CRD_W'(`MUL_WB_CREDITS))
		else begin
			failCount++;
			$error("credit returned while writeback held no result");
		end

	// one pop frees one slot, so each credit is a single cycle pulse
	reqCreditPulse: assert property (@(posedge clk) disable iff (rst)
		reqCredit |=> !reqCredit)
		else begin
			failCount++;
			$error("request credit held high for more than one cycle");
		end

	// outputs stay quiet through reset and in the first cycle after it
	quietReset: assert property (@(posedge clk)
		(rst || $past(rst)) |=> (!rspValid && !reqCredit))
		else begin
			failCount++;
			$error("response valid or request credit high around reset");
		end

endmodule

bind mulUnit mulUnit_chk chk_i (
	.clk       (clk),
	.rst       (rst),
	.reqCredit (reqCredit),
	.rspValid  (rspValid),
	.rspCredit (rspCredit),
	.rspCrd    (rspCrd)
);

`default_nettype wire

//--- tb/mulUnit_tb.sv
// testbench for the multiply unit
// reads requests, expected products and writeback stalls from tb/mul_input.txt
// and runs them through the DUT with credit models on both sides

`timescale 1ns/100ps
`default_nettype none

`include "mul_cfg.svh"

module mulUnit_tb
	import mulReqPkg::*;
	import mulRspPkg::*;
();

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 10;
	localparam int FIELDS          = 7;
	localparam int MAX_LINES       = 64;
	localparam int BURST_START     = 8;
	localparam int CYCLES_PER_LINE = 40;

	logic    clk = 1'b0;
	logic    rst;
	logic    reqValid;
	mulReq_t reqData;
	logic    reqCredit;
	logic    rspValid;
	mulRsp_t rspData;
	logic    rspCredit = 1'b0;

	// one word per field, seven fields per line of the input file
	logic [127:0] vecMem [MAX_LINES*FIELDS];
	int           numLines = 0;
	logic         loaded = 1'b0;

	// issuer credits, writeback credits and the writeback release times
	int reqCrd = `MUL_REQ_DEPTH;
	int wbCrd = `MUL_WB_CREDITS;
	int cycle = 0;
	int rspIdx = 0;
	int relQ[$];

	always #(CLK_PERIOD/2) clk = ~clk;

	mulUnit dut_i (
		.clk       (clk),
		.rst       (rst),
		.reqValid  (reqValid),
		.reqData   (reqData),
		.reqCredit (reqCredit),
		.rspValid  (rspValid),
		.rspData   (rspData),
		.rspCredit (rspCredit)
	);

	mulScoreboard sb_i (
		.clk       (clk),
		.rst       (rst),
		.reqValid  (reqValid),
		.reqCredit (reqCredit),
		.rspValid  (rspValid),
		.rspData   (rspData),
		.wbCrd     (wbCrd)
	);

	function automatic logic [127:0] vecField(input int line, input int col);
		return vecMem[line*FIELDS + col];
	endfunction

	// advance to the next falling edge and collect a returned request credit
	task automatic nextCycle();
		@(negedge clk);
		if (reqCredit) begin
			reqCrd++;
		end
	endtask

	task automatic driveLine(input int line);
		reqValid          = 1'b1;
		reqData.tag       = mulTag_t'(vecField(line, 0));
		reqData.op        = mulOp_t'(vecField(line, 1));
		reqData.a         = mulWord_t'(vecField(line, 2));
		reqData.b         = mulWord_t'(vecField(line, 3));
		reqData.imm       = mulWord_t'(vecField(line, 4));
		sb_i.addExpected(reqData.tag, mulProduct_t'(vecField(line, 5)));
	endtask

	// ==================================================
	// writeback model
	// ==================================================

	// each result holds a credit for the stall count of its own line
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (rst) begin
			wbCrd <= `MUL_WB_CREDITS;
		end else begin
			case ({rspValid, rspCredit})
				2'b10:   wbCrd <= wbCrd - 1;
				2'b01:   wbCrd <= wbCrd + 1;
				default: wbCrd <= wbCrd;
			endcase
			if (rspValid) begin
				relQ.push_back(cycle + ((rspIdx < numLines) ? int'(vecField(rspIdx, 6)) : 0));
				rspIdx <= rspIdx + 1;
			end
		end
	end

	// at most one credit goes back per cycle, oldest result first
	always @(negedge clk) begin
		if (relQ.size() > 0 && relQ[0] <= cycle) begin
			rspCredit = 1'b1;
			void'(relQ.pop_front());
		end else begin
			rspCredit = 1'b0;
		end
	end

	// ==================================================
	// main sequence
	// ==================================================

	initial begin : mainSeq
		int i;
		int line;
		int gap;
		int loadErrs;
		void'($urandom(32'h9aeae253));
		rst      = 1'b1;
		reqValid = 1'b0;
		reqData  = '0;
		loadErrs = 0;

		// unread entries keep a pattern whose tag word can never be a real tag
		for (i = 0; i < MAX_LINES*FIELDS; i++) begin
			vecMem[i] = {4{~i[31:0]}};
		end
		$readmemh("tb/mul_input.txt", vecMem);
		while (numLines < MAX_LINES && vecMem[numLines*FIELDS] < 128'd16) begin
			numLines++;
		end
		loaded = 1'b1;
		if (numLines == 0) begin
			$display("no request lines could be read from tb/mul_input.txt");
			loadErrs++;
		end

		if (numLines > 0) begin
			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;

			// early lines get random idle gaps, the rest go out back to back
			line = 0;
			gap  = 0;
			while (line < numLines) begin
				nextCycle();
				reqValid = 1'b0;
				if (gap > 0) begin
					gap--;
				end else if (reqCrd > 0) begin
					driveLine(line);
					reqCrd--;
					line++;
					gap = (line < BURST_START) ? int'($urandom % 4) : 0;
				end
			end
			nextCycle();
			reqValid = 1'b0;

			// drain until every result is back, then look for stragglers
			while (rspIdx < numLines) begin
				nextCycle();
			end
			repeat (8) nextCycle();
			sb_i.checkDrain(reqCrd);
		end

		$display("errors: data %0d, protocol %0d, assertion %0d, setup %0d",
			sb_i.dataErrs, sb_i.protoErrs, dut_i.chk_i.failCount, loadErrs);
		if (sb_i.dataErrs + sb_i.protoErrs + dut_i.chk_i.failCount + loadErrs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// the limit grows with the number of lines in the input file
	initial begin : watchdog
		wait (loaded);
		#((numLines * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles",
			numLines * CYCLES_PER_LINE + RESET_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/mul_input.txt
// columns: tag op a b imm expected_product stall, all in hex
// op bit 1 selects signed, bit 0 selects imm; stall is the writeback delay in cycles
0 0 3 5 0 f 0
1 0 ffffffffffffffff ffffffffffffffff 0 fffffffffffffffe0000000000000001 1
2 0 123456789abcdef0 10 0 123456789abcdef00 2
3 0 100000000 100000000 0 10000000000000000 0
4 1 7 ffff 6 2a 3
5 1 ffffffffffffffff 2 ffffffffffffffff fffffffffffffffe0000000000000001 1
6 2 fffffffffffffffd 5 0 fffffffffffffffffffffffffffffff1 0
7 2 3 fffffffffffffffb 0 fffffffffffffffffffffffffffffff1 2
8 2 fffffffffffffffd fffffffffffffffb 0 f 0
9 2 0 fffffffffffffff0 0 0 0
a 2 8000000000000000 2 0 ffffffffffffffff0000000000000000 0
b 2 8000000000000000 8000000000000000 0 40000000000000000000000000000000 0
c 2 8000000000000000 ffffffffffffffff 0 8000000000000000 14
d 3 fffffffffffffffe 3 fffffffffffffff9 e 14
e 3 a 0 ffffffffffffffff fffffffffffffffffffffffffffffff6 14
f 0 ffffffffffffffff 2 0 1fffffffffffffffe 14
0 0 2 3 0 6 1e
1 2 ffffffffffffffff ffffffffffffffff 0 1 1e
2 1 1000 5 1000 1000000 1e
3 0 deadbeef 1 0 deadbeef 1e

//--- sim.f
+incdir+include
logic/mulReqPkg.sv
logic/mulRspPkg.sv
logic/creditFifo.sv
logic/mulOperandSel.sv
logic/mulIterCore.sv
logic/mulUnit.sv
tb/mulScoreboard.sv
tb/mulUnit_chk.sv
tb/mulUnit_tb.sv

//--- Bender.yml
package:
  name: mul_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/mulReqPkg.sv
      - logic/mulRspPkg.sv
      - logic/creditFifo.sv
      - logic/mulOperandSel.sv
      - logic/mulIterCore.sv
      - logic/mulUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/mulScoreboard.sv
      - tb/mulUnit_chk.sv
      - tb/mulUnit_tb.sv
